//--- flist.f
design/snakePkg.sv
design/snakeHead.sv
design/bodySegment.sv
design/blockPlotter.sv
design/gameController.sv
design/snakeTop.sv
test/snakeTop_props.sv
test/snakeTb.sv

//--- Makefile
# Verilator build and run of the snake testbench

VERILATOR ?= verilator
TOP       ?= snakeTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# a failing run ends in $$fatal, so the exit status carries the result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- test/snakeTb.sv
`timescale 1ns/1ps

module snakeTb
    import snakePkg::*;
();

    localparam int BlockSize = 10;
    localparam int SnakeLength = 4;
    localparam int TickCycles = 50;
    // one frame tick plus pass sequencing fits well inside this
    localparam int WaitLimit = 4 * TickCycles;

    logic       Clock;
    logic       reset;
    logic       go;
    logic [3:0] keyN;
    colour_t    snakeColour;
    xCoord_t    plotX;
    yCoord_t    plotY;
    colour_t    plotColour;
    logic       plot;
    logic       gameOver;

    // reference snake, block origins in pixels
    int         modelHeadX;
    int         modelHeadY;
    int         modelSegX [SnakeLength];
    int         modelSegY [SnakeLength];
    direction_t modelDir;
    integer     seed;

    snakeTop #(
        .blockSize(BlockSize),
        .snakeLength(SnakeLength),
        .tickCycles(TickCycles)
    ) i_snakeTop
    (
        .Clock(Clock),
        .reset(reset),
        .go(go),
        .keyN(keyN),
        .snakeColour(snakeColour),
        .plotX(plotX),
        .plotY(plotY),
        .plotColour(plotColour),
        .plot(plot),
        .gameOver(gameOver)
    );

    initial Clock = 1'b0;
    always #5 Clock = ~Clock;

    task automatic checkValue(input string what, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $fatal(1, "stopped on a timeout");
    endtask

    // active-low keys, priority right, down, up, left
    function automatic direction_t keyDirection(input logic [3:0] keys, input direction_t cur);
        direction_t d;
        d = cur;
        if (!keys[0])
            d = dirRight;
        else if (!keys[1])
            d = dirDown;
        else if (!keys[2])
            d = dirUp;
        else if (!keys[3])
            d = dirLeft;
        return d;
    endfunction

    // one block move on the torus
    function automatic int wrapStep(input int value, input int delta, input int size);
        return (value + delta + size) % size;
    endfunction

    task automatic nextHead(input direction_t d, output int nx, output int ny);
        nx = modelHeadX;
        ny = modelHeadY;
        case (d)
            dirUp:   ny = wrapStep(modelHeadY, -BlockSize, ScreenHeight);
            dirDown: ny = wrapStep(modelHeadY, BlockSize, ScreenHeight);
            dirLeft: nx = wrapStep(modelHeadX, -BlockSize, ScreenWidth);
            default: nx = wrapStep(modelHeadX, BlockSize, ScreenWidth);
        endcase
    endtask

    // body after the step is the old head plus all but the tail
    function automatic bit landsOnBody(input int nx, input int ny);
        bit hit;
        hit = (nx == modelHeadX) && (ny == modelHeadY);
        for (int i = 0; i < SnakeLength - 1; i++)
            hit = hit || ((nx == modelSegX[i]) && (ny == modelSegY[i]));
        return hit;
    endfunction

    task automatic stepModel(output bit hit);
        int nx;
        int ny;
        nextHead(modelDir, nx, ny);
        hit = landsOnBody(nx, ny);
        for (int i = SnakeLength - 1; i > 0; i--)
        begin
            modelSegX[i] = modelSegX[i-1];
            modelSegY[i] = modelSegY[i-1];
        end
        modelSegX[0] = modelHeadX;
        modelSegY[0] = modelHeadY;
        modelHeadX = nx;
        modelHeadY = ny;
    endtask

    // random key pattern whose step does not hit the body
    task automatic chooseSafeKeys(output logic [3:0] keys);
        int nx;
        int ny;
        int tries;
        tries = 0;
        keys = 4'($random(seed));
        nextHead(keyDirection(keys, modelDir), nx, ny);
        while (landsOnBody(nx, ny) && tries < 16)
        begin
            keys = 4'($random(seed));
            nextHead(keyDirection(keys, modelDir), nx, ny);
            tries++;
        end
        // at most two neighbours of the head are body, so a single key always works
        for (int k = 0; k < 4; k++)
        begin
            if (landsOnBody(nx, ny))
            begin
                keys = ~(4'b0001 << k);
                nextHead(keyDirection(keys, modelDir), nx, ny);
            end
        end
    endtask

    task automatic waitForPlot(output int gap);
        gap = 0;
        while (!plot && gap < WaitLimit)
        begin
            @(negedge Clock);
            gap++;
        end
        if (!plot)
            reportTimeout("plot did not start within the wait limit");
    endtask

    // head first, then segments, rows top down, x fastest
    task automatic checkPass(input colour_t colour, input int expectedGap);
        int gap;
        int ox;
        int oy;
        waitForPlot(gap);
        if (expectedGap >= 0)
            checkValue("idle cycles before draw pass", gap, expectedGap);
        for (int b = 0; b <= SnakeLength; b++)
        begin
            if (b == 0)
            begin
                ox = modelHeadX;
                oy = modelHeadY;
            end
            else
            begin
                ox = modelSegX[b-1];
                oy = modelSegY[b-1];
            end
            for (int r = 0; r < BlockSize; r++)
            begin
                for (int c = 0; c < BlockSize; c++)
                begin
                    checkValue("plot", int'(plot), 1);
                    checkValue("plotX", int'(plotX), ox + c);
                    checkValue("plotY", int'(plotY), oy + r);
                    checkValue("plotColour", int'(plotColour), int'(colour));
                    @(negedge Clock);
                end
            end
        end
        checkValue("plot after pass end", int'(plot), 0);
    endtask

    // key pulse and new colour just after a draw pass
    task automatic runFrame(input logic [3:0] keys, output bit hit);
        keyN = keys;
        snakeColour = colour_t'($random(seed));
        @(negedge Clock);
        keyN = 4'hF;
        modelDir = keyDirection(keys, modelDir);
        checkPass(EraseColour, -1);
        stepModel(hit);
        // erase end, step, check, draw start take fixed cycles
        if (!hit)
            checkPass(snakeColour, 2);
    endtask

    task automatic steerFrames(input logic [3:0] keys, input int frames);
        bit hit;
        for (int i = 0; i < frames; i++)
        begin
            runFrame(keys, hit);
            checkValue("collision while steering", int'(hit), 0);
        end
    endtask

    initial
    begin
        bit         hit;
        logic [3:0] keys;
        int         nx;
        int         ny;
        int         upRun;
        int         count;

        seed = 32'h682d;
        reset = 1'b1;
        go = 1'b0;
        keyN = 4'hF;
        snakeColour = '0;
        modelDir = dirUp;
        modelHeadX = int'(StartX);
        modelHeadY = int'(StartY);
        for (int i = 0; i < SnakeLength; i++)
        begin
            modelSegX[i] = int'(StartX);
            modelSegY[i] = int'(StartY) + BlockSize * (i + 1);
        end
        repeat (4) @(negedge Clock);
        reset = 1'b0;

        // nothing happens until go
        repeat (20)
        begin
            checkValue("plot while idle", int'(plot), 0);
            checkValue("gameOver while idle", int'(gameOver), 0);
            @(negedge Clock);
        end

        snakeColour = colour_t'($random(seed));
        go = 1'b1;
        checkPass(snakeColour, -1);

        // random steering
        repeat (12)
        begin
            chooseSafeKeys(keys);
            runFrame(keys, hit);
            checkValue("gameOver during random steering", int'(gameOver), 0);
        end

        // head up with the body straight below
        upRun = 0;
        count = 0;
        while (upRun < SnakeLength && count < 40)
        begin
            keys = 4'b1011;
            nextHead(dirUp, nx, ny);
            if (landsOnBody(nx, ny))
            begin
                keys = 4'b0111;
                nextHead(dirLeft, nx, ny);
                if (landsOnBody(nx, ny))
                    keys = 4'b1110;
            end
            runFrame(keys, hit);
            checkValue("collision while straightening", int'(hit), 0);
            upRun = (modelDir == dirUp) ? upRun + 1 : 0;
            count++;
        end
        checkValue("body straightened below head", (upRun >= SnakeLength) ? 1 : 0, 1);

        // 17 columns left and 13 rows up both cross a screen edge
        steerFrames(4'b0111, 17);
        steerFrames(4'b1011, 13);

        // left, down, right puts the head on the tail segment
        steerFrames(4'b0111, 1);
        steerFrames(4'b1101, 1);
        runFrame(4'b1110, hit);
        checkValue("collision after left, down, right", int'(hit), 1);

        count = 0;
        while (!gameOver && count < WaitLimit)
        begin
            @(negedge Clock);
            count++;
        end
        if (!gameOver)
            reportTimeout("gameOver did not rise after the collision");
        checkValue("cycles from erase end to gameOver", count, 2);

        // no drawing after game over
        repeat (3 * TickCycles)
        begin
            checkValue("plot after game over", int'(plot), 0);
            checkValue("gameOver held", int'(gameOver), 1);
            @(negedge Clock);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- test/snakeTop_props.sv
`timescale 1ns/1ps

module snakeTop_props import snakePkg::*;
(
    input logic    Clock,
    input logic    reset,
    input logic    plot,
    input logic    gameOver,
    input xCoord_t plotX,
    input yCoord_t plotY
);

    // plot stream stops once the game is over
    plotNotOver: assert property (@(posedge Clock) disable iff (reset)
        !(plot && gameOver))
        else $error("plot strobe high while gameOver is set");

    // game over holds until reset
    overSticky: assert property (@(posedge Clock) disable iff (reset)
        gameOver |=> gameOver)
        else $error("gameOver dropped without a reset");

    // every plotted pixel lies inside the 160x120 frame
    plotOnScreen: assert property (@(posedge Clock) disable iff (reset)
        plot |-> (int'(plotX) < ScreenWidth) && (int'(plotY) < ScreenHeight))
        else $error("plot coordinates off screen");

endmodule

bind snakeTop snakeTop_props i_snakeTopProps
(
    .Clock(Clock),
    .reset(reset),
    .plot(plot),
    .gameOver(gameOver),
    .plotX(plotX),
    .plotY(plotY)
);

//--- design/snakeTop.sv
`timescale 1ns/1ps

module snakeTop import snakePkg::*;
#(
    parameter int blockSize = 10,
    parameter int snakeLength = 4,
    parameter int tickCycles = 1000000
)
(
    input  logic       Clock,
    input  logic       reset,
    input  logic       go,
    input  logic [3:0] keyN,
    input  colour_t    snakeColour,
    output xCoord_t    plotX,
    output yCoord_t    plotY,
    output colour_t    plotColour,
    output logic       plot,
    output logic       gameOver
);

    xCoord_t                headX;
    yCoord_t                headY;
    xCoord_t                prevX;
    yCoord_t                prevY;
    xCoord_t                segX [snakeLength];
    yCoord_t                segY [snakeLength];
    xCoord_t                segInX [snakeLength];
    yCoord_t                segInY [snakeLength];
    logic [snakeLength-1:0] headHits;
    logic                   step;
    logic                   passStart;
    colour_t                passColour;
    logic                   passDone;

    snakeHead #(.blockSize(blockSize)) i_snakeHead
    (
        .Clock(Clock),
        .reset(reset),
        .keyN(keyN),
        .step(step),
        .headX(headX),
        .headY(headY),
        .prevX(prevX),
        .prevY(prevY)
    );

    // body chain, segment 0 follows the head
    for (genvar i = 0; i < snakeLength; i++)
    begin : g_body
        if (i == 0)
        begin : g_first
            assign segInX[i] = prevX;
            assign segInY[i] = prevY;
        end
        else
        begin : g_rest
            assign segInX[i] = segX[i-1];
            assign segInY[i] = segY[i-1];
        end

        // start column stacked below the head
        bodySegment #(
            .blockSize(blockSize),
            .startY(yCoord_t'((StartY + blockSize * (i + 1)) % ScreenHeight))
        ) i_bodySegment
        (
            .Clock(Clock),
            .reset(reset),
            .step(step),
            .inX(segInX[i]),
            .inY(segInY[i]),
            .headX(headX),
            .headY(headY),
            .segX(segX[i]),
            .segY(segY[i]),
            .headHit(headHits[i])
        );
    end

    blockPlotter #(.blockSize(blockSize), .snakeLength(snakeLength)) i_blockPlotter
    (
        .Clock(Clock),
        .reset(reset),
        .passStart(passStart),
        .passColour(passColour),
        .headX(headX),
        .headY(headY),
        .segXs(segX),
        .segYs(segY),
        .plotX(plotX),
        .plotY(plotY),
        .plotColour(plotColour),
        .plot(plot),
        .passDone(passDone)
    );

    gameController #(.snakeLength(snakeLength), .tickCycles(tickCycles)) i_gameController
    (
        .Clock(Clock),
        .reset(reset),
        .go(go),
        .snakeColour(snakeColour),
        .passDone(passDone),
        .headHits(headHits),
        .step(step),
        .passStart(passStart),
        .passColour(passColour),
        .gameOver(gameOver)
    );

endmodule

//--- design/gameController.sv
`timescale 1ns/1ps

module gameController import snakePkg::*;
#(
    parameter int snakeLength = 4,
    parameter int tickCycles = 1000000
)
(
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   go,
    input  colour_t                snakeColour,
    input  logic                   passDone,
    input  logic [snakeLength-1:0] headHits,
    output logic                   step,
    output logic                   passStart,
    output colour_t                passColour,
    output logic                   gameOver
);

    localparam int TickBits = $clog2(tickCycles + 1);

    gameState_t           state;
    gameState_t           nextState;
    logic [TickBits-1:0]  tickCount;
    logic                 tick;
    logic                 anyHit;

    // free-running frame divider
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else if (tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    // one cycle every tickCycles clocks
    assign tick = (tickCount == TickBits'(tickCycles - 1));

    // any segment under the head after the step
    assign anyHit = |headHits;

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= stIdle;
        else
            state <= nextState;
    end

    // frame sequence
    // draw, wait for tick, erase, step, check, draw again
    always_comb
    begin
        nextState = state;
        passStart = 1'b0;
        case (state)
            stIdle:
            begin
                if (go)
                begin
                    passStart = 1'b1;
                    nextState = stDraw;
                end
            end
            stDraw:
            begin
                if (passDone)
                    nextState = stWaitTick;
            end
            stWaitTick:
            begin
                // erase pass starts on the frame tick
                if (tick)
                begin
                    passStart = 1'b1;
                    nextState = stErase;
                end
            end
            stErase:
            begin
                if (passDone)
                    nextState = stStep;
            end
            stStep:
                nextState = stCheck;
            stCheck:
            begin
                // hit flags already see the moved head
                if (anyHit)
                    nextState = stOver;
                else
                begin
                    passStart = 1'b1;
                    nextState = stDraw;
                end
            end
            stOver:
                nextState = stOver;
            default:
                nextState = stIdle;
        endcase
    end

    // head and body shift on this cycle's edge
    assign step = (state == stStep);
    // only the erase pass starts from stWaitTick
    assign passColour = (state == stWaitTick) ? EraseColour : snakeColour;
    // held until reset
    assign gameOver = (state == stOver);

endmodule

//--- design/blockPlotter.sv
`timescale 1ns/1ps

module blockPlotter import snakePkg::*;
#(
    parameter int blockSize = 10,
    parameter int snakeLength = 4
)
(
    input  logic    Clock,
    input  logic    reset,
    input  logic    passStart,
    input  colour_t passColour,
    input  xCoord_t headX,
    input  yCoord_t headY,
    input  xCoord_t segXs [snakeLength],
    input  yCoord_t segYs [snakeLength],
    output xCoord_t plotX,
    output yCoord_t plotY,
    output colour_t plotColour,
    output logic    plot,
    output logic    passDone
);

    // block 0 is the head, block i+1 is segment i
    localparam int BlockBits = $clog2(snakeLength + 1);
    localparam int OffBits = $clog2(blockSize + 1);

    logic [BlockBits-1:0] blockIdx;
    logic [OffBits-1:0]   offX;
    logic [OffBits-1:0]   offY;
    logic                 active;
    colour_t              colourReg;
    xCoord_t              originX;
    yCoord_t              originY;
    logic                 emit;
    logic                 lastX;
    logic                 lastY;
    logic                 lastBlock;
    logic                 lastPixel;

    // origin of the block being drawn
    always_comb
    begin
        originX = headX;
        originY = headY;
        for (int i = 0; i < snakeLength; i++)
        begin
            if (blockIdx == BlockBits'(i + 1))
            begin
                originX = segXs[i];
                originY = segYs[i];
            end
        end
    end

    // counters idle at zero, so pixel 0 goes out on the start cycle
    assign emit = passStart || active;
    assign lastX = (offX == OffBits'(blockSize - 1));
    assign lastY = (offY == OffBits'(blockSize - 1));
    assign lastBlock = (blockIdx == BlockBits'(snakeLength));
    assign lastPixel = lastX && lastY && lastBlock;

    // x runs fastest, then rows, then blocks
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            active <= 1'b0;
            blockIdx <= '0;
            offX <= '0;
            offY <= '0;
            plot <= 1'b0;
            passDone <= 1'b0;
        end
        else
        begin
            plot <= emit;
            passDone <= emit && lastPixel;
            if (emit)
            begin
                active <= !lastPixel;
                if (!lastX)
                    offX <= offX + 1'b1;
                else
                begin
                    offX <= '0;
                    if (!lastY)
                        offY <= offY + 1'b1;
                    else
                    begin
                        offY <= '0;
                        // wraps back to the head after the last segment
                        blockIdx <= lastBlock ? '0 : blockIdx + 1'b1;
                    end
                end
            end
        end
    end

    // pixel outputs, valid while plot is high
    always_ff @(posedge Clock)
    begin
        if (passStart)
            colourReg <= passColour;
        plotX <= originX + xCoord_t'(offX);
        plotY <= originY + yCoord_t'(offY);
        // first pixel uses the colour presented with the start strobe
        plotColour <= passStart ? passColour : colourReg;
    end

endmodule

//--- design/bodySegment.sv
`timescale 1ns/1ps

module bodySegment import snakePkg::*;
#(
    parameter int      blockSize = 10,
    parameter yCoord_t startY = StartY
)
(
    input  logic    Clock,
    input  logic    reset,
    input  logic    step,
    input  xCoord_t inX,
    input  yCoord_t inY,
    input  xCoord_t headX,
    input  yCoord_t headY,
    output xCoord_t segX,
    output yCoord_t segY,
    output logic    headHit
);

    localparam xCoord_t SizeX = xCoord_t'(blockSize);
    localparam yCoord_t SizeY = yCoord_t'(blockSize);

    logic overlapX;
    logic overlapY;

    // shift stage of the body chain
    // all segments start in the head's column
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segX <= StartX;
            segY <= startY;
        end
        else if (step)
        begin
            segX <= inX;
            segY <= inY;
        end
    end

    // box overlap of head and segment
    // blocks sit on the block grid, so this is a position match
    assign overlapX = (headX < segX + SizeX) && (headX + SizeX > segX);
    assign overlapY = (headY < segY + SizeY) && (headY + SizeY > segY);
    assign headHit = overlapX && overlapY;

endmodule

//--- design/snakeHead.sv
`timescale 1ns/1ps

module snakeHead import snakePkg::*;
#(
    parameter int blockSize = 10
)
(
    input  logic       Clock,
    input  logic       reset,
    input  logic [3:0] keyN,
    input  logic       step,
    output xCoord_t    headX,
    output yCoord_t    headY,
    output xCoord_t    prevX,
    output yCoord_t    prevY
);

    // one block step in each axis
    localparam xCoord_t StepX = xCoord_t'(blockSize);
    localparam yCoord_t StepY = yCoord_t'(blockSize);
    // last block origin before the screen edge
    localparam xCoord_t LastX = xCoord_t'(ScreenWidth - blockSize);
    localparam yCoord_t LastY = yCoord_t'(ScreenHeight - blockSize);

    direction_t dir;
    xCoord_t nextX;
    yCoord_t nextY;

    // keys are active low
    // priority right, down, up, left; no key keeps the last direction
    always_ff @(posedge Clock)
    begin
        if (reset)
            dir <= dirUp;
        else if (!keyN[0])
            dir <= dirRight;
        else if (!keyN[1])
            dir <= dirDown;
        else if (!keyN[2])
            dir <= dirUp;
        else if (!keyN[3])
            dir <= dirLeft;
    end

    // next head origin, wraps to the far edge
    always_comb
    begin
        nextX = headX;
        nextY = headY;
        case (dir)
            dirUp:    nextY = (headY < StepY) ? LastY : headY - StepY;
            dirDown:  nextY = (headY >= LastY) ? '0 : headY + StepY;
            dirLeft:  nextX = (headX < StepX) ? LastX : headX - StepX;
            dirRight: nextX = (headX >= LastX) ? '0 : headX + StepX;
            default:
            begin
                nextX = headX;
                nextY = headY;
            end
        endcase
    end

    // head moves only on the controller's step strobe
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            headX <= StartX;
            headY <= StartY;
        end
        else if (step)
        begin
            headX <= nextX;
            headY <= nextY;
        end
    end

    // old head, taken by segment 0 on the same step edge
    assign prevX = headX;
    assign prevY = headY;

endmodule

//--- design/snakePkg.sv
package snakePkg;

    // plotter screen size in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // pixel coordinate widths match the 160x120 frame buffer
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    // 3-bit rgb colour
    typedef logic [2:0] colour_t;

    // background colour, used by the erase pass
    localparam colour_t EraseColour = 3'd0;

    // head start position, screen centre
    localparam xCoord_t StartX = 8'd80;
    localparam yCoord_t StartY = 7'd60;

    // held steering direction
    typedef enum logic [1:0]
    {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } direction_t;

    // frame sequencing states
    typedef enum logic [2:0]
    {
        stIdle,
        stDraw,
        stWaitTick,
        stErase,
        stStep,
        stCheck,
        stOver
    } gameState_t;

endpackage
